//--- src/nes_bus_pkg.sv
package nes_bus_pkg;

	// CPU side bus
	typedef logic [15:0] addr_t;	// 6502 address bus
	typedef logic [7:0]  data_t;	// 6502 data bus

	// Fixed register addresses on the CPU bus
	localparam addr_t OAM_DATA_ADDR = 16'h2004;	// PPU OAM data port, target of every sprite write
	localparam addr_t OAM_DMA_ADDR  = 16'h4014;	// Sprite DMA trigger, data is the source page
	localparam addr_t JOY1_ADDR     = 16'h4016;	// Joypad 1, writes also set the strobe
	localparam addr_t JOY2_ADDR     = 16'h4017;	// Joypad 2

	// Sprite DMA state
	// Bit 0 marks DMA active, bit 1 marks DMA owning the bus
	typedef enum logic [1:0] {
		SPR_IDLE = 2'b00,
		SPR_WAIT = 2'b01,	// Waiting for an odd CPU read cycle
		SPR_RUN  = 2'b11	// Alternating read / write pairs
	} spr_state_e;

	// DMC sample fetch state
	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1	// Request taken, ack on the next even cycle
	} dmc_state_e;

	// Where the read data on the bus comes from
	typedef enum logic [1:0] {
		SRC_MEM  = 2'd0,
		SRC_JOY1 = 2'd1,
		SRC_JOY2 = 2'd2,
		SRC_OPEN = 2'd3	// Nothing drives the bus, last value floats
	} rd_src_e;

endpackage

//--- src/clock_enable_gen.sv
`timescale 1ns/10ps

// Master clock dividers for the CPU and PPU enables
// Cyc  123456789ABC123456789ABC
// CPU  -----------C-----------C
// PPU  ---P---P---P---P---P---P
module clock_enable_gen #(
	parameter int cpu_div = 12,	// Master clocks per CPU cycle
	parameter int ppu_div = 4	// Master clocks per PPU cycle
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,	// One clock wide, once per CPU cycle
	output logic ppu_ce,	// One clock wide, once per PPU cycle
	output logic odd_cycle	// 1 = odd, 0 = even
);
	localparam int cpu_w = $clog2(cpu_div);
	localparam int ppu_w = $clog2(ppu_div);
	localparam logic [cpu_w-1:0] cpu_last = cpu_w'(cpu_div - 1);
	localparam logic [ppu_w-1:0] ppu_last = ppu_w'(ppu_div - 1);

	logic [cpu_w-1:0] cpu_cnt;
	logic [ppu_w-1:0] ppu_cnt;

	// Enables fire on the last count of each period
	assign cpu_ce = (cpu_cnt == cpu_last);
	assign ppu_ce = (ppu_cnt == ppu_last);

	// Free running wrap counters
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt <= '0;
			ppu_cnt <= '0;
		end else begin
			cpu_cnt <= cpu_ce ? '0 : cpu_cnt + 1'b1;
			ppu_cnt <= ppu_ce ? '0 : ppu_cnt + 1'b1;
		end
	end

	// Odd/even CPU cycle, starts odd out of reset
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b1;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;	// Flips once per CPU cycle
	end

	// Enables must stay single clock pulses
	a_cpu_ce_pulse: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce)
		else $error("cpu_ce high for two clocks");

	a_ppu_ce_pulse: assert property (@(posedge clk) disable iff (reset)
		ppu_ce |=> !ppu_ce)
		else $error("ppu_ce high for two clocks");

endmodule

//--- src/dma_controller.sv
`timescale 1ns/10ps

// Sprite DMA and DMC sample fetch
// Sprite DMA reads page xx00..xxFF on even cycles, writes each byte to
// the OAM data port on the following odd cycle
// DMC steals an even cycle, an interrupted sprite pair is simply redone
module dma_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_ce,
	input  logic                odd_cycle,
	input  logic                sprite_trigger,	// CPU write to 0x4014 this cycle
	input  nes_bus_pkg::data_t  sprite_page,	// Source page of the sprite copy
	input  logic                cpu_rnw,	// CPU is in a read cycle
	input  nes_bus_pkg::data_t  from_bus,	// Read data on the bus
	input  logic                dmc_req,
	input  nes_bus_pkg::addr_t  dmc_addr,
	output logic                dma_enable,	// DMA owns the bus
	output logic                dma_read,	// 1 = read, 0 = write
	output nes_bus_pkg::addr_t  dma_addr,
	output nes_bus_pkg::data_t  dma_wdata,
	output logic                dmc_ack,
	output logic                pause_cpu
);
	import nes_bus_pkg::*;

	spr_state_e spr_state;
	dmc_state_e dmc_state;
	data_t      spr_page;	// High byte of the sprite source
	data_t      spr_offset;	// Byte index within the page
	data_t      spr_data;	// Byte read on the even cycle

	logic spr_run;
	logic spr_last;

	assign spr_run  = (spr_state == SPR_RUN);
	assign spr_last = (spr_offset == 8'hff);	// Final pair of the page

	// Both state machines step once per CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= DMC_IDLE;
		end else if (cpu_ce) begin
			case (dmc_state)
				DMC_IDLE: begin
					// Only taken on an even read cycle
					if (dmc_req && cpu_rnw && !odd_cycle)
						dmc_state <= DMC_FETCH;
				end
				DMC_FETCH: begin
					if (!odd_cycle)
						dmc_state <= DMC_IDLE;	// Ack cycle done
				end
				default: dmc_state <= DMC_IDLE;
			endcase

			if (sprite_trigger) begin
				spr_state <= SPR_WAIT;	// Restart on any trigger
			end else begin
				case (spr_state)
					SPR_IDLE: ;
					SPR_WAIT: begin
						// First pair starts with the next even cycle
						if (cpu_rnw && odd_cycle)
							spr_state <= SPR_RUN;
					end
					SPR_RUN: begin
						if (!odd_cycle && dmc_state == DMC_FETCH)
							spr_state <= SPR_WAIT;	// DMC took the read slot
						else if (odd_cycle && spr_last)
							spr_state <= SPR_IDLE;
					end
					default: spr_state <= SPR_IDLE;
				endcase
			end
		end
	end

	// Sprite address and byte latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				spr_page   <= sprite_page;
				spr_offset <= 8'h00;
			end else if (spr_run && odd_cycle) begin
				spr_offset <= spr_offset + 8'd1;	// Advance after the write
			end
			if (spr_run && !odd_cycle)
				spr_data <= from_bus;	// Held for the odd cycle write
		end
	end

	assign dmc_ack    = (dmc_state == DMC_FETCH) && !odd_cycle;
	assign dma_enable = dmc_ack || spr_run;
	assign dma_read   = !odd_cycle;	// Reads even, writes odd
	assign dma_wdata  = spr_data;
	assign pause_cpu  = (spr_state != SPR_IDLE) || dmc_req;

	// DMC first, then sprite read, then the OAM port
	assign dma_addr = dmc_ack ? dmc_addr :
		!odd_cycle ? {spr_page, spr_offset} : OAM_DATA_ADDR;

	// Ack only on an even cycle of a live request
	a_dmc_ack_even: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> (!odd_cycle && dmc_req))
		else $error("dmc_ack outside an even cycle of a request");

endmodule

//--- src/cpu_bus.sv
`timescale 1ns/10ps

// CPU side bus unit
// Picks the bus master, decodes the DMA trigger and joypad ports,
// keeps the open bus value and returns read data
module cpu_bus (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_ce,
	input  nes_bus_pkg::addr_t  cpu_addr,
	input  nes_bus_pkg::data_t  cpu_wdata,
	input  logic                cpu_rnw,
	input  logic                dma_enable,
	input  logic                dma_read,
	input  nes_bus_pkg::addr_t  dma_addr,
	input  nes_bus_pkg::data_t  dma_wdata,
	input  nes_bus_pkg::data_t  mem_rdata,	// Combinational memory read
	input  logic [4:0]          joy1_data,
	input  logic [4:0]          joy2_data,
	output nes_bus_pkg::addr_t  bus_addr,
	output nes_bus_pkg::data_t  bus_wdata,
	output logic                bus_read,
	output logic                bus_write,
	output logic                sprite_trigger,
	output nes_bus_pkg::data_t  sprite_page,
	output nes_bus_pkg::data_t  from_bus,	// Selected read data
	output nes_bus_pkg::data_t  cpu_rdata,
	output logic [2:0]          joy_strobe,	// Strobe lines to the pads
	output logic [1:0]          joy_clock	// Bit 0 pad 1, bit 1 pad 2
);
	import nes_bus_pkg::*;

	rd_src_e rd_src;
	data_t   open_bus;	// Last value seen on the data bus
	logic    joy1_sel;
	logic    joy2_sel;

	// Bus master mux
	assign bus_addr  = dma_enable ? dma_addr  : cpu_addr;
	assign bus_wdata = dma_enable ? dma_wdata : cpu_wdata;
	assign bus_read  = dma_enable ? dma_read  : cpu_rnw;
	assign bus_write = dma_enable ? !dma_read : !cpu_rnw;

	// Register decode on the shared bus
	assign joy1_sel = (bus_addr == JOY1_ADDR);
	assign joy2_sel = (bus_addr == JOY2_ADDR);

	assign sprite_trigger = bus_write && (bus_addr == OAM_DMA_ADDR);
	assign sprite_page    = bus_wdata;	// Page number comes with the trigger write

	assign joy_clock = {joy2_sel && bus_read, joy1_sel && bus_read};

	// Read source
	always_comb begin
		if (!bus_read)
			rd_src = SRC_OPEN;	// Write cycle, hold the floating value
		else if (joy1_sel)
			rd_src = SRC_JOY1;
		else if (joy2_sel)
			rd_src = SRC_JOY2;
		else
			rd_src = SRC_MEM;
	end

	// Pads only drive the low five bits
	always_comb begin
		case (rd_src)
			SRC_MEM:  from_bus = mem_rdata;
			SRC_JOY1: from_bus = {open_bus[7:5], joy1_data};
			SRC_JOY2: from_bus = {open_bus[7:5], joy2_data};
			default:  from_bus = open_bus;
		endcase
	end

	assign cpu_rdata = from_bus;

	// Strobe latch on a write to 0x4016
	always_ff @(posedge clk) begin
		if (reset)
			joy_strobe <= 3'b000;
		else if (cpu_ce && bus_write && joy1_sel)
			joy_strobe <= bus_wdata[2:0];
	end

	// Open bus follows the data bus every CPU cycle
	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= 8'h00;
		else if (cpu_ce)
			open_bus <= from_bus;
	end

	// DMA only ever writes the OAM data port
	a_dma_write_oam: assert property (@(posedge clk) disable iff (reset)
		(dma_enable && bus_write) |-> (bus_addr == OAM_DATA_ADDR))
		else $error("DMA write outside the OAM data port");

endmodule

//--- src/nes_bus_top.sv
`timescale 1ns/10ps

// CPU side bus unit of the console core
module nes_bus_top #(
	parameter int cpu_div = 12,	// Master clocks per CPU cycle
	parameter int ppu_div = 4	// Master clocks per PPU cycle
) (
	input  logic                clk,
	input  logic                reset,
	// CPU side
	input  nes_bus_pkg::addr_t  cpu_addr,
	input  nes_bus_pkg::data_t  cpu_wdata,
	input  logic                cpu_rnw,
	output nes_bus_pkg::data_t  cpu_rdata,
	output logic                pause_cpu,
	// Memory side
	input  nes_bus_pkg::data_t  mem_rdata,
	output nes_bus_pkg::addr_t  bus_addr,
	output nes_bus_pkg::data_t  bus_wdata,
	output logic                bus_read,
	output logic                bus_write,
	// DMC requester
	input  logic                dmc_req,
	input  nes_bus_pkg::addr_t  dmc_addr,
	output logic                dmc_ack,
	// Joypads
	input  logic [4:0]          joy1_data,
	input  logic [4:0]          joy2_data,
	output logic [2:0]          joy_strobe,
	output logic [1:0]          joy_clock,
	// Enables
	output logic                cpu_ce,
	output logic                ppu_ce
);
	import nes_bus_pkg::*;

	logic  odd_cycle;
	logic  sprite_trigger;
	data_t sprite_page;
	data_t from_bus;
	logic  dma_enable;
	logic  dma_read;
	addr_t dma_addr;
	data_t dma_wdata;

	clock_enable_gen #(
		.cpu_div   (cpu_div),
		.ppu_div   (ppu_div)
	) u_clock_enable_gen (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller u_dma_controller (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.cpu_rnw        (cpu_rnw),
		.from_bus       (from_bus),
		.dmc_req        (dmc_req),
		.dmc_addr       (dmc_addr),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.dma_addr       (dma_addr),
		.dma_wdata      (dma_wdata),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	cpu_bus u_cpu_bus (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.cpu_rnw        (cpu_rnw),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.dma_addr       (dma_addr),
		.dma_wdata      (dma_wdata),
		.mem_rdata      (mem_rdata),
		.joy1_data      (joy1_data),
		.joy2_data      (joy2_data),
		.bus_addr       (bus_addr),
		.bus_wdata      (bus_wdata),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.from_bus       (from_bus),
		.cpu_rdata      (cpu_rdata),
		.joy_strobe     (joy_strobe),
		.joy_clock      (joy_clock)
	);

endmodule

//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Memory behind the bus, one random byte per address
logic [7:0] mem [0:65535];
int         seed   = 10532;
int         errors = 0;
int         checks = 0;

// Expected DMA bus cycles in bus order
addr_t exp_addr[$];
data_t exp_data[$];
logic  exp_wr[$];	// 1 = write

task automatic fill_memory();
	for (int a = 0; a < 65536; a++)
		mem[a] = 8'($random(seed));
endtask

task automatic clear_expected();
	exp_addr.delete();
	exp_data.delete();
	exp_wr.delete();
endtask

// Sprite DMA copies xx00..xxFF, each read followed by a write of
// the same byte to the OAM data port
task automatic expect_sprite_dma(input data_t page);
	addr_t a;
	clear_expected();
	for (int n = 0; n < 256; n++) begin
		a = {page, 8'(n)};
		exp_addr.push_back(a);	// Even cycle read
		exp_data.push_back(mem[a]);
		exp_wr.push_back(1'b0);
		exp_addr.push_back(OAM_DATA_ADDR);	// Odd cycle write
		exp_data.push_back(mem[a]);
		exp_wr.push_back(1'b1);
	end
endtask

task automatic check_equal(input string what, input int got, input int exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
	end
endtask

`endif

//--- dv/tb_nes_bus.sv
`timescale 1ns/10ps

module tb_nes_bus;
	import nes_bus_pkg::*;

	localparam int    cpu_div      = 12;
	localparam int    ppu_div      = 4;
	localparam addr_t idle_addr    = 16'h5000;	// CPU parks here, outside page and DMC ranges
	localparam int    timeout_clks = 25000;	// 3 DMAs x 530 cycles x 12 clocks, plus the rest

	logic       clk;
	logic       reset;
	addr_t      cpu_addr;
	data_t      cpu_wdata;
	logic       cpu_rnw;
	data_t      cpu_rdata;
	logic       pause_cpu;
	data_t      mem_rdata;
	addr_t      bus_addr;
	data_t      bus_wdata;
	logic       bus_read;
	logic       bus_write;
	logic       dmc_req;
	addr_t      dmc_addr;
	logic       dmc_ack;
	logic [4:0] joy1_data;
	logic [4:0] joy2_data;
	logic [2:0] joy_strobe;
	logic [1:0] joy_clock;
	logic       cpu_ce;
	logic       ppu_ce;

	`include "tb_model.svh"

	// DMA owned bus cycles, taken at the end of each CPU cycle
	addr_t obs_addr[$];
	data_t obs_data[$];
	logic  obs_wr[$];
	logic  obs_rd[$];
	logic  obs_odd[$];
	logic  odd;	// Parity of the current CPU cycle

	// End of cycle samples
	data_t      last_rdata;
	logic [1:0] last_joy_clock;
	logic       last_pause;
	logic       last_req;
	logic       last_ack;
	int         clk_count = 0;

	nes_bus_top #(.cpu_div(cpu_div), .ppu_div(ppu_div)) UUT (.*);

	assign mem_rdata = mem[bus_addr];	// Combinational read

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Any cycle where the bus differs from the CPU address belongs to DMA
	always @(negedge clk) begin
		if (reset) begin
			odd = 1'b1;	// First CPU cycle is odd
		end else if (cpu_ce) begin
			if (bus_addr != cpu_addr) begin
				obs_addr.push_back(bus_addr);
				obs_data.push_back(bus_write ? bus_wdata : cpu_rdata);
				obs_wr.push_back(bus_write);
				obs_rd.push_back(bus_read);
				obs_odd.push_back(odd);
			end
			odd = !odd;
		end
	end

	always @(posedge clk) begin
		clk_count <= clk_count + 1;
		if (clk_count >= timeout_clks) begin
			$display("Timeout: the run did not finish within %0d clocks", timeout_clks);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// One CPU cycle, also the DMC requester side of the ack
	task automatic cpu_cycle(input addr_t addr, input data_t wdata, input logic rnw);
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_rnw   = rnw;
		do @(negedge clk); while (!cpu_ce);
		last_rdata     = cpu_rdata;
		last_joy_clock = joy_clock;
		last_pause     = pause_cpu;
		last_req       = dmc_req;
		last_ack       = dmc_ack;
		if (dmc_ack) begin
			check_equal("DMC ack address", int'(bus_addr), int'(dmc_addr));
			check_equal("DMC sample byte", int'(cpu_rdata), int'(mem[dmc_addr]));
		end
		@(posedge clk);
		#1;
		if (last_ack)
			dmc_req = 1'b0;	// Byte taken at this edge
	endtask

	// DMC reads are pulled out, everything else must match in order
	task automatic check_dma_trace(input int first, input int exp_dmc);
		int k;
		int dmc_seen;
		int extra;
		k        = 0;
		dmc_seen = 0;
		extra    = 0;
		for (int i = first; i < obs_addr.size(); i++) begin
			if (obs_addr[i] == dmc_addr && !obs_wr[i]) begin
				dmc_seen++;
				check_equal("DMC read on an even cycle", int'(obs_odd[i]), 0);
				check_equal("DMC read strobe", int'(obs_rd[i]), 1);
			end else if (k < exp_addr.size()) begin
				check_equal("DMA address", int'(obs_addr[i]), int'(exp_addr[k]));
				check_equal("DMA data", int'(obs_data[i]), int'(exp_data[k]));
				check_equal("DMA direction", int'(obs_wr[i]), int'(exp_wr[k]));
				check_equal("DMA read strobe", int'(obs_rd[i]), int'(!exp_wr[k]));
				check_equal("read even, write odd", int'(obs_odd[i]), int'(exp_wr[k]));
				k++;
			end else begin
				extra++;
			end
		end
		check_equal("sprite DMA cycles", k, exp_addr.size());
		check_equal("unexpected DMA cycles", extra, 0);
		check_equal("DMC reads", dmc_seen, exp_dmc);
	endtask

	task automatic sprite_dma(input logic steal);
		data_t page;
		int    first;
		int    steal_at;
		int    n;
		page     = 8'($random(seed)) & 8'h3f;	// Pages 00..3F
		steal_at = steal ? int'({$random(seed)} % 480) : -1;
		expect_sprite_dma(page);
		first = obs_addr.size();
		cpu_cycle(OAM_DMA_ADDR, page, 1'b0);	// Trigger
		n = 0;
		do begin
			if (n == steal_at) begin
				dmc_addr = {2'b11, 14'($random(seed))};
				dmc_req  = 1'b1;
			end
			cpu_cycle(idle_addr, 8'h00, 1'b1);
			if (n == 0)
				check_equal("pause_cpu after trigger", int'(last_pause), 1);
			n++;
		end while (last_pause && n < 600);
		check_equal("pause_cpu at end of sprite DMA", int'(last_pause), 0);
		check_dma_trace(first, steal ? 1 : 0);
	endtask

	task automatic dmc_only();
		int first;
		int n;
		clear_expected();
		first    = obs_addr.size();
		dmc_addr = {2'b11, 14'($random(seed))};
		dmc_req  = 1'b1;
		n        = 0;
		do begin
			cpu_cycle(idle_addr, 8'h00, 1'b1);
			check_equal("pause_cpu follows dmc_req", int'(last_pause), int'(last_req));
			n++;
		end while (dmc_req && n < 8);
		if (dmc_req) begin
			$display("DMC request for %0h was never acknowledged", dmc_addr);
			errors++;
			dmc_req = 1'b0;
		end
		cpu_cycle(idle_addr, 8'h00, 1'b1);
		check_equal("pause_cpu after DMC", int'(last_pause), 0);
		check_dma_trace(first, 1);
	endtask

	task automatic joypads();
		data_t prev;
		data_t wd;
		prev = mem[idle_addr];
		wd   = 8'($random(seed));
		cpu_cycle(idle_addr, 8'h00, 1'b1);
		check_equal("memory read", int'(last_rdata), int'(prev));
		cpu_cycle(JOY1_ADDR, wd, 1'b0);	// Write leaves the open bus alone
		check_equal("joy_strobe", int'(joy_strobe), int'(wd[2:0]));
		joy1_data = 5'($random(seed));
		joy2_data = 5'($random(seed));
		cpu_cycle(JOY1_ADDR, 8'h00, 1'b1);
		check_equal("joy_clock pad 1", int'(last_joy_clock), 1);
		check_equal("pad 1 data", int'(last_rdata), int'({prev[7:5], joy1_data}));
		cpu_cycle(JOY2_ADDR, 8'h00, 1'b1);	// Upper bits still from memory read
		check_equal("joy_clock pad 2", int'(last_joy_clock), 2);
		check_equal("pad 2 data", int'(last_rdata), int'({prev[7:5], joy2_data}));
		cpu_cycle(idle_addr, 8'h00, 1'b1);
		check_equal("joy_clock idle", int'(last_joy_clock), 0);
	endtask

	initial begin
		reset     = 1'b1;
		cpu_addr  = idle_addr;
		cpu_wdata = 8'h00;
		cpu_rnw   = 1'b1;
		dmc_req   = 1'b0;
		dmc_addr  = 16'hc000;
		joy1_data = 5'h00;
		joy2_data = 5'h00;
		fill_memory();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < 4 * cpu_div; i++) begin	// Clock index since reset fell
			@(negedge clk);
			check_equal("cpu_ce timing", int'(cpu_ce), int'(i % cpu_div == cpu_div - 1));
			check_equal("ppu_ce timing", int'(ppu_ce), int'(i % ppu_div == ppu_div - 1));
			check_equal("idle outputs",
				int'({pause_cpu, dmc_ack, bus_write, joy_clock, joy_strobe}), 0);
		end
		@(posedge clk);
		#1;
		sprite_dma(1'b0);
		sprite_dma(1'b1);
		sprite_dma(1'b1);
		repeat (4) dmc_only();
		repeat (4) joypads();
		$display("Errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+dv
src/nes_bus_pkg.sv
src/clock_enable_gen.sv
src/dma_controller.sv
src/cpu_bus.sv
src/nes_bus_top.sv
dv/tb_nes_bus.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bus unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timing -f project.f --top-module tb_nes_bus \
	--Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$build_dir/sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$log_file"; then
	exit 0
fi
exit 1
